// File: spmv_types_pkg.sv
// datapath types and default sizes for the spmv accelerator
// value, accumulator and row index words shared by every block
`default_nettype none

package spmv_types_pkg;

    localparam int VAL_W     = 16;  // matrix and x values
    localparam int ACC_W     = 32;  // products and row sums
    localparam int ROW_W     = 16;  // row index and row count
    localparam int XI_ADDR_W = 16;  // column index and Xi port address

    // signed fixed-point value, one nonzero or one x entry
    typedef logic signed [VAL_W-1:0] val_t;

    // row accumulator, wraps modulo 2^32
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef logic [ROW_W-1:0] row_t;

    localparam int DEF_NUM_KERNEL = 4;   // parallel calc kernels
    localparam int DEF_XI_DEPTH   = 64;  // x entries held per kernel

endpackage

`default_nettype wire

// File: spmv_regmap_pkg.sv
// register map of the spmv config block
// three words per kernel: control, row base and completed-row status
`default_nettype none

package spmv_regmap_pkg;

    localparam int CFG_WORDS_PER_KERNEL = 3;

    // word offsets inside one kernel's group
    localparam int CFG_CTRL      = 0;
    localparam int CFG_ROW_BASE  = 1;
    localparam int CFG_ROWS_DONE = 2;  // read only

    localparam int CTRL_ENABLE_BIT   = 0;
    localparam int CTRL_SOFT_RST_BIT = 7;  // holds the kernel in reset while set

    // field view of the control word, msb first
    typedef struct packed {
        logic [23:0] rsvd_hi;
        logic        soft_rst;  // bit 7
        logic [5:0]  rsvd_lo;
        logic        enable;    // bit 0
    } ctrl_view_t;

    // register block keeps raw words, kernels look at the field view
    typedef union packed {
        logic [31:0] raw;
        ctrl_view_t  ctl;
    } cfg_word_u;

endpackage

`default_nettype wire

// File: spmv_system_config.sv
// per-kernel configuration and status registers
// single-cycle strobe writes, reads answer one cycle later
`timescale 1ns/10ps
`default_nettype none

module spmv_system_config #(
    parameter int  NUM_KERNEL = spmv_types_pkg::DEF_NUM_KERNEL,
    localparam int CFG_AW     = $clog2(NUM_KERNEL * spmv_regmap_pkg::CFG_WORDS_PER_KERNEL)
) (
    input  logic                                        arst_n,
    input  logic                                        axis_clk,
    input  logic                                        cfg_wr,
    input  logic                                        cfg_rd,
    input  logic [CFG_AW-1:0]                           cfg_addr,
    input  logic [31:0]                                 cfg_wdata,
    output logic [31:0]                                 cfg_rdata,
    output logic                                        cfg_rvalid,
    input  spmv_types_pkg::row_t      [NUM_KERNEL-1:0]  rows_done,
    output spmv_regmap_pkg::cfg_word_u [NUM_KERNEL-1:0] cfg_ctrl,
    output spmv_types_pkg::row_t      [NUM_KERNEL-1:0]  row_base
);

    logic [NUM_KERNEL-1:0][31:0] base_q;  // full row-base words, read back raw
    logic [31:0]                 rd_word;

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_ctrl <= '0;  // every kernel starts disabled
            base_q   <= '0;
        end else if (cfg_wr) begin
            for (int k = 0; k < NUM_KERNEL; k++) begin
                if (cfg_addr == k * spmv_regmap_pkg::CFG_WORDS_PER_KERNEL +
                                spmv_regmap_pkg::CFG_CTRL) begin
                    cfg_ctrl[k].raw <= cfg_wdata;
                end
                if (cfg_addr == k * spmv_regmap_pkg::CFG_WORDS_PER_KERNEL +
                                spmv_regmap_pkg::CFG_ROW_BASE) begin
                    base_q[k] <= cfg_wdata;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            row_base[k] = spmv_types_pkg::row_t'(base_q[k]);  // low half feeds the kernel
        end
    end

    // read mux, unmapped addresses fall through as zero
    always_comb begin
        rd_word = '0;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (cfg_addr == k * spmv_regmap_pkg::CFG_WORDS_PER_KERNEL +
                            spmv_regmap_pkg::CFG_CTRL) begin
                rd_word = cfg_ctrl[k].raw;
            end
            if (cfg_addr == k * spmv_regmap_pkg::CFG_WORDS_PER_KERNEL +
                            spmv_regmap_pkg::CFG_ROW_BASE) begin
                rd_word = base_q[k];
            end
            if (cfg_addr == k * spmv_regmap_pkg::CFG_WORDS_PER_KERNEL +
                            spmv_regmap_pkg::CFG_ROWS_DONE) begin
                rd_word = {16'b0, rows_done[k]};  // live count from the kernel
            end
        end
    end

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= cfg_rd;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (cfg_rd) begin
            cfg_rdata <= rd_word;
        end
    end

    a_no_rd_wr_overlap: assert property (@(posedge axis_clk) disable iff (!arst_n)
        !(cfg_rd && cfg_wr))
        else $error("cfg_rd and cfg_wr high in the same cycle");

    for (genvar k = 0; k < NUM_KERNEL; k++) begin : g_chk
        // kernel must drop its row count one edge after soft reset is seen
        a_soft_rst_clears: assert property (@(posedge axis_clk) disable iff (!arst_n)
            cfg_ctrl[k].raw[spmv_regmap_pkg::CTRL_SOFT_RST_BIT] |=> rows_done[k] == '0)
            else $error("kernel %0d row count not cleared by soft reset", k);

        // once the pipeline has drained, a disabled kernel completes no rows
        a_idle_stable: assert property (@(posedge axis_clk) disable iff (!arst_n)
            (!cfg_ctrl[k].raw[spmv_regmap_pkg::CTRL_ENABLE_BIT] &&
             !cfg_ctrl[k].raw[spmv_regmap_pkg::CTRL_SOFT_RST_BIT]) [*3]
            |=> $stable(rows_done[k]))
            else $error("disabled kernel %0d completed a row", k);
    end

endmodule

`default_nettype wire

// File: xi_buffer.sv
// x vector store of one calc kernel
// shared Xi write port, registered read with one cycle latency
`timescale 1ns/10ps
`default_nettype none

module xi_buffer #(
    parameter int  XI_DEPTH  = spmv_types_pkg::DEF_XI_DEPTH,
    parameter int  KERNEL_ID = 0,
    localparam int IDX_W     = $clog2(XI_DEPTH)
) (
    input  logic                                 axis_clk,
    input  logic                                 xi_wr,
    input  logic [spmv_types_pkg::XI_ADDR_W-1:0] xi_addr,
    input  spmv_types_pkg::val_t                 xi_wdata,
    input  logic [IDX_W-1:0]                     rd_addr,
    output spmv_types_pkg::val_t                 rd_data
);

    spmv_types_pkg::val_t mem [XI_DEPTH];
    logic                 wr_sel;

    // upper address bits carry the kernel number
    assign wr_sel = xi_wr &&
                    (xi_addr[spmv_types_pkg::XI_ADDR_W-1:IDX_W] == KERNEL_ID);

    always_ff @(posedge axis_clk) begin
        if (wr_sel) begin
            mem[xi_addr[IDX_W-1:0]] <= xi_wdata;  // entry field
        end
    end

    always_ff @(posedge axis_clk) begin
        rd_data <= mem[rd_addr];  // old data on a same-cycle write
    end

endmodule

`default_nettype wire

// File: spmv_calc_kernel.sv
// spmv calc kernel, multiply-accumulate of one row's nonzeros against x
// emits the row sum with its global row index on the last nonzero
`timescale 1ns/10ps
`default_nettype none

module spmv_calc_kernel #(
    parameter int  XI_DEPTH = spmv_types_pkg::DEF_XI_DEPTH,
    localparam int IDX_W    = $clog2(XI_DEPTH)
) (
    input  logic                                 arst_n,
    input  logic                                 axis_clk,
    input  spmv_regmap_pkg::cfg_word_u           ctrl,
    input  spmv_types_pkg::row_t                 row_base,
    input  logic                                 nz_valid,
    input  logic [spmv_types_pkg::XI_ADDR_W-1:0] nz_col,
    input  spmv_types_pkg::val_t                 nz_val,
    input  logic                                 nz_last,
    output logic [IDX_W-1:0]                     xi_rd_addr,
    input  spmv_types_pkg::val_t                 xi_rd_data,
    output logic                                 res_valid,
    output spmv_types_pkg::row_t                 res_row,
    output spmv_types_pkg::acc_t                 res_data,
    output spmv_types_pkg::row_t                 rows_done
);

    // stage 1 issues the x read, stage 2 meets the returned x
    logic                 s1_valid;
    logic [IDX_W-1:0]     s1_col;
    spmv_types_pkg::val_t s1_val;
    logic                 s1_last;
    logic                 s2_valid;
    spmv_types_pkg::val_t s2_val;
    logic                 s2_last;

    spmv_types_pkg::acc_t acc;
    spmv_types_pkg::acc_t prod;
    spmv_types_pkg::acc_t acc_sum;

    assign xi_rd_addr = s1_col;
    assign prod       = s2_val * xi_rd_data;  // signed, sign-extended to 32 bits
    assign acc_sum    = acc + prod;           // wraps

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            res_valid <= 1'b0;
            acc       <= '0;
            rows_done <= '0;
        end else if (ctrl.ctl.soft_rst) begin
            s1_valid  <= 1'b0;  // drop whatever is in flight
            s2_valid  <= 1'b0;
            res_valid <= 1'b0;
            acc       <= '0;
            rows_done <= '0;
        end else begin
            s1_valid  <= nz_valid && ctrl.ctl.enable;
            s2_valid  <= s1_valid;
            res_valid <= s2_valid && s2_last;
            if (s2_valid) begin
                if (s2_last) begin
                    acc       <= '0;  // next row starts clean
                    rows_done <= rows_done + 1'b1;
                end else begin
                    acc <= acc_sum;
                end
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        s1_col  <= nz_col[IDX_W-1:0];
        s1_val  <= nz_val;
        s1_last <= nz_last;
        s2_val  <= s1_val;
        s2_last <= s1_last;
        if (s2_valid && s2_last) begin
            res_data <= acc_sum;
            res_row  <= row_base + rows_done;  // global row index
        end
    end

    a_col_in_range: assert property (@(posedge axis_clk) disable iff (!arst_n)
        nz_valid && ctrl.ctl.enable |-> nz_col < XI_DEPTH)
        else $error("nz_col %0d beyond x store depth %0d", nz_col, XI_DEPTH);

endmodule

`default_nettype wire

// File: result_arbiter.sv
// round-robin merge of kernel row results onto one output stream
// one hold slot per kernel, one slot drained per cycle
`timescale 1ns/10ps
`default_nettype none

module result_arbiter #(
    parameter int  NUM_KERNEL = spmv_types_pkg::DEF_NUM_KERNEL,
    localparam int KID_W      = (NUM_KERNEL > 1) ? $clog2(NUM_KERNEL) : 1
) (
    input  logic                                  arst_n,
    input  logic                                  axis_clk,
    input  logic                 [NUM_KERNEL-1:0] k_res_valid,
    input  spmv_types_pkg::row_t [NUM_KERNEL-1:0] k_res_row,
    input  spmv_types_pkg::acc_t [NUM_KERNEL-1:0] k_res_data,
    output logic                                  res_valid,
    output logic [KID_W-1:0]                      res_kernel,
    output spmv_types_pkg::row_t                  res_row,
    output spmv_types_pkg::acc_t                  res_data
);

    logic                 [NUM_KERNEL-1:0] slot_full;
    spmv_types_pkg::row_t [NUM_KERNEL-1:0] slot_row;
    spmv_types_pkg::acc_t [NUM_KERNEL-1:0] slot_data;

    logic [KID_W-1:0]      last_gnt;  // search starts just after this one
    logic                  gnt_any;
    logic [KID_W-1:0]      gnt_idx;
    logic [NUM_KERNEL-1:0] drain;

    always_comb begin : p_pick
        int idx;
        gnt_any = 1'b0;
        gnt_idx = last_gnt;
        drain   = '0;
        for (int i = 1; i <= NUM_KERNEL; i++) begin
            idx = int'(last_gnt) + i;
            if (idx >= NUM_KERNEL) begin
                idx = idx - NUM_KERNEL;  // wrap around the ring
            end
            if (!gnt_any && slot_full[idx]) begin
                gnt_any = 1'b1;
                gnt_idx = KID_W'(idx);
            end
        end
        if (gnt_any) begin
            drain[gnt_idx] = 1'b1;
        end
    end

    always_ff @(posedge axis_clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_full <= '0;
            last_gnt  <= '0;
            res_valid <= 1'b0;
        end else begin
            slot_full <= k_res_valid | (slot_full & ~drain);  // refill allowed while draining
            res_valid <= gnt_any;
            if (gnt_any) begin
                last_gnt <= gnt_idx;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (k_res_valid[k]) begin
                slot_row[k]  <= k_res_row[k];
                slot_data[k] <= k_res_data[k];
            end
        end
        res_kernel <= gnt_idx;
        res_row    <= slot_row[gnt_idx];
        res_data   <= slot_data[gnt_idx];
    end

    // kernels finishing rows too close together would overwrite a waiting result
    for (genvar k = 0; k < NUM_KERNEL; k++) begin : g_chk
        a_slot_overrun: assert property (@(posedge axis_clk) disable iff (!arst_n)
            k_res_valid[k] |-> !slot_full[k] || drain[k])
            else $error("kernel %0d result arrived while its hold slot was full", k);
    end

endmodule

`default_nettype wire

// File: spmv_calc_top.sv
// spmv accelerator top, config block, per-kernel x stores and calc kernels
// kernel results are merged onto one stream by the result arbiter
`timescale 1ns/10ps
`default_nettype none

module spmv_calc_top #(
    parameter int  NUM_KERNEL = spmv_types_pkg::DEF_NUM_KERNEL,
    parameter int  XI_DEPTH   = spmv_types_pkg::DEF_XI_DEPTH,
    localparam int CFG_AW     = $clog2(NUM_KERNEL * spmv_regmap_pkg::CFG_WORDS_PER_KERNEL),
    localparam int KID_W      = (NUM_KERNEL > 1) ? $clog2(NUM_KERNEL) : 1,
    localparam int IDX_W      = $clog2(XI_DEPTH)
) (
    input  logic                                                   axis_clk,
    input  logic                                                   arst_n,
    input  logic                                                   cfg_wr,
    input  logic                                                   cfg_rd,
    input  logic [CFG_AW-1:0]                                      cfg_addr,
    input  logic [31:0]                                            cfg_wdata,
    output logic [31:0]                                            cfg_rdata,
    output logic                                                   cfg_rvalid,
    input  logic                                                   xi_wr,
    input  logic [spmv_types_pkg::XI_ADDR_W-1:0]                   xi_addr,
    input  spmv_types_pkg::val_t                                   xi_wdata,
    input  logic [NUM_KERNEL-1:0]                                  nz_valid,
    input  logic [NUM_KERNEL-1:0][spmv_types_pkg::XI_ADDR_W-1:0]   nz_col,
    input  spmv_types_pkg::val_t [NUM_KERNEL-1:0]                  nz_val,
    input  logic [NUM_KERNEL-1:0]                                  nz_last,
    output logic                                                   res_valid,
    output logic [KID_W-1:0]                                       res_kernel,
    output spmv_types_pkg::row_t                                   res_row,
    output spmv_types_pkg::acc_t                                   res_data
);

    spmv_regmap_pkg::cfg_word_u [NUM_KERNEL-1:0]            cfg_ctrl;
    spmv_types_pkg::row_t       [NUM_KERNEL-1:0]            row_base;
    spmv_types_pkg::row_t       [NUM_KERNEL-1:0]            rows_done;
    logic                       [NUM_KERNEL-1:0][IDX_W-1:0] xi_rd_addr;
    spmv_types_pkg::val_t       [NUM_KERNEL-1:0]            xi_rd_data;
    logic                       [NUM_KERNEL-1:0]            k_res_valid;
    spmv_types_pkg::row_t       [NUM_KERNEL-1:0]            k_res_row;
    spmv_types_pkg::acc_t       [NUM_KERNEL-1:0]            k_res_data;

    spmv_system_config #(
        .NUM_KERNEL (NUM_KERNEL)
    ) spmv_system_config_inst (
        .arst_n     (arst_n),
        .axis_clk   (axis_clk),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .rows_done  (rows_done),
        .cfg_ctrl   (cfg_ctrl),
        .row_base   (row_base)
    );

    for (genvar k = 0; k < NUM_KERNEL; k++) begin : g_kernel
        xi_buffer #(
            .XI_DEPTH  (XI_DEPTH),
            .KERNEL_ID (k)
        ) xi_buffer_inst (
            .axis_clk (axis_clk),
            .xi_wr    (xi_wr),
            .xi_addr  (xi_addr),
            .xi_wdata (xi_wdata),
            .rd_addr  (xi_rd_addr[k]),
            .rd_data  (xi_rd_data[k])
        );

        spmv_calc_kernel #(
            .XI_DEPTH (XI_DEPTH)
        ) spmv_calc_kernel_inst (
            .arst_n     (arst_n),
            .axis_clk   (axis_clk),
            .ctrl       (cfg_ctrl[k]),
            .row_base   (row_base[k]),
            .nz_valid   (nz_valid[k]),
            .nz_col     (nz_col[k]),
            .nz_val     (nz_val[k]),
            .nz_last    (nz_last[k]),
            .xi_rd_addr (xi_rd_addr[k]),
            .xi_rd_data (xi_rd_data[k]),
            .res_valid  (k_res_valid[k]),
            .res_row    (k_res_row[k]),
            .res_data   (k_res_data[k]),
            .rows_done  (rows_done[k])
        );
    end

    result_arbiter #(
        .NUM_KERNEL (NUM_KERNEL)
    ) result_arbiter_inst (
        .arst_n      (arst_n),
        .axis_clk    (axis_clk),
        .k_res_valid (k_res_valid),
        .k_res_row   (k_res_row),
        .k_res_data  (k_res_data),
        .res_valid   (res_valid),
        .res_kernel  (res_kernel),
        .res_row     (res_row),
        .res_data    (res_data)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// testbench clock and reset source
// free running axis_clk, arst_n held low for the first cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RST_CYCLES     = 2
) (
    output logic axis_clk,
    output logic arst_n
);

    initial begin
        axis_clk = 1'b0;
        forever #(HALF_PERIOD_NS) axis_clk = ~axis_clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge axis_clk);
        arst_n <= 1'b1;  // release on an edge
    end

endmodule

`default_nettype wire

// File: tb_spmv_calc_top.sv
// testbench of the spmv accelerator top
// reference model with shadow registers, x stores and per-kernel result queues
`timescale 1ns/10ps
`default_nettype none

module tb_spmv_calc_top;

    localparam int NK     = spmv_types_pkg::DEF_NUM_KERNEL;
    localparam int XD     = spmv_types_pkg::DEF_XI_DEPTH;
    localparam int WPK    = spmv_regmap_pkg::CFG_WORDS_PER_KERNEL;
    localparam int CFG_AW = $clog2(NK * WPK);
    localparam int KID_W  = (NK > 1) ? $clog2(NK) : 1;
    localparam int IDX_W  = $clog2(XD);
    localparam int EN     = spmv_regmap_pkg::CTRL_ENABLE_BIT;
    localparam int SOFT   = spmv_regmap_pkg::CTRL_SOFT_RST_BIT;
    localparam int TMO    = 2000;  // cycles allowed per wait

    logic                                axis_clk;
    logic                                arst_n;
    logic                                cfg_wr;
    logic                                cfg_rd;
    logic [CFG_AW-1:0]                   cfg_addr;
    logic [31:0]                         cfg_wdata;
    logic [31:0]                         cfg_rdata;
    logic                                cfg_rvalid;
    logic                                xi_wr;
    logic [15:0]                         xi_addr;
    spmv_types_pkg::val_t                xi_wdata;
    logic [NK-1:0]                       nz_valid;
    logic [NK-1:0][15:0]                 nz_col;
    spmv_types_pkg::val_t [NK-1:0]       nz_val;
    logic [NK-1:0]                       nz_last;
    logic                                res_valid;
    logic [KID_W-1:0]                    res_kernel;
    logic [15:0]                         res_row;
    logic [31:0]                         res_data;

    // reference model state
    logic [31:0]        ctrl_sh [NK];
    logic [31:0]        base_sh [NK];
    logic [15:0]        rows_cnt [NK];
    logic signed [31:0] acc_sh [NK];
    logic signed [15:0] x_sh [NK][XD];
    logic [15:0]        exp_row_q [NK][$];
    logic [31:0]        exp_data_q [NK][$];
    logic [15:0]        head_row [NK];
    logic [31:0]        head_data [NK];
    logic [NK-1:0]      head_ok;
    logic               req_seen;
    logic               rd_pending;
    logic [31:0]        rd_expect;
    int                 streams_done;

    tb_clock_gen tb_clock_gen_inst (
        .axis_clk (axis_clk),
        .arst_n   (arst_n)
    );

    spmv_calc_top #(
        .NUM_KERNEL (NK),
        .XI_DEPTH   (XD)
    ) spmv_calc_top_inst (
        .axis_clk   (axis_clk),
        .arst_n     (arst_n),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .xi_wr      (xi_wr),
        .xi_addr    (xi_addr),
        .xi_wdata   (xi_wdata),
        .nz_valid   (nz_valid),
        .nz_col     (nz_col),
        .nz_val     (nz_val),
        .nz_last    (nz_last),
        .res_valid  (res_valid),
        .res_kernel (res_kernel),
        .res_row    (res_row),
        .res_data   (res_data)
    );

    task automatic stop_with_fail();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[FAIL] time %0t %s expected 0x%08h actual 0x%08h",
                 $time, name, expected, actual);
        stop_with_fail();
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        stop_with_fail();
    endtask

    function automatic int outstanding();
        int total;
        total = 0;
        for (int k = 0; k < NK; k++) begin
            total += exp_row_q[k].size();
        end
        return total;
    endfunction

    // model sees every input on the same edge as the DUT
    always @(posedge axis_clk or negedge arst_n) begin : ref_model
        int                 ka;
        int                 off;
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic signed [31:0] prod;
        if (!arst_n) begin
            for (int k = 0; k < NK; k++) begin
                ctrl_sh[k]  = '0;
                base_sh[k]  = '0;
                rows_cnt[k] = '0;
                acc_sh[k]   = '0;
                exp_row_q[k].delete();
                exp_data_q[k].delete();
            end
            req_seen   = 1'b0;
            rd_pending = 1'b0;
            rd_expect  = '0;
        end else begin
            if (cfg_wr || cfg_rd || xi_wr || (|nz_valid)) begin
                req_seen = 1'b1;
            end
            for (int k = 0; k < NK; k++) begin
                if (ctrl_sh[k][SOFT]) begin
                    acc_sh[k]   = '0;
                    rows_cnt[k] = '0;
                end else if (nz_valid[k] && ctrl_sh[k][EN]) begin
                    a    = signed'(nz_val[k]);
                    b    = signed'(x_sh[k][nz_col[k] % XD]);
                    prod = a * b;
                    if (nz_last[k]) begin
                        exp_row_q[k].push_back(16'(base_sh[k]) + rows_cnt[k]);
                        exp_data_q[k].push_back(acc_sh[k] + prod);  // wraps at 32 bits
                        acc_sh[k]   = '0;
                        rows_cnt[k] = rows_cnt[k] + 16'd1;
                    end else begin
                        acc_sh[k] = acc_sh[k] + prod;
                    end
                end
            end
            if (res_valid && exp_row_q[res_kernel].size() > 0) begin
                void'(exp_row_q[res_kernel].pop_front());
                void'(exp_data_q[res_kernel].pop_front());
            end
            ka         = int'(cfg_addr) / WPK;
            off        = int'(cfg_addr) % WPK;
            rd_pending = cfg_rd;
            if (cfg_rd) begin
                rd_expect = '0;  // unmapped address
                if (ka < NK) begin
                    case (off)
                        spmv_regmap_pkg::CFG_CTRL:      rd_expect = ctrl_sh[ka];
                        spmv_regmap_pkg::CFG_ROW_BASE:  rd_expect = base_sh[ka];
                        spmv_regmap_pkg::CFG_ROWS_DONE: rd_expect = {16'b0, rows_cnt[ka]};
                        default:                        rd_expect = '0;
                    endcase
                end
            end
            if (cfg_wr && ka < NK) begin
                if (off == spmv_regmap_pkg::CFG_CTRL) begin
                    ctrl_sh[ka] = cfg_wdata;
                end else if (off == spmv_regmap_pkg::CFG_ROW_BASE) begin
                    base_sh[ka] = cfg_wdata;
                end
            end
            if (xi_wr && int'(xi_addr >> IDX_W) < NK) begin
                x_sh[int'(xi_addr >> IDX_W)][xi_addr[IDX_W-1:0]] = xi_wdata;
            end
        end
        for (int k = 0; k < NK; k++) begin
            head_ok[k] = exp_row_q[k].size() > 0;
            if (head_ok[k]) begin
                head_row[k]  = exp_row_q[k][0];
                head_data[k] = exp_data_q[k][0];
            end
        end
    end

    // outputs are checked mid-cycle, where they are stable
    a_quiet_before_request: assert property (@(negedge axis_clk) disable iff (!arst_n)
        !req_seen |-> !res_valid && !cfg_rvalid)
        else abort_run("output strobe raised before any request");

    a_rvalid_timing: assert property (@(negedge axis_clk) disable iff (!arst_n)
        cfg_rvalid == rd_pending)
        else abort_run("cfg_rvalid not high for exactly the cycle after cfg_rd");

    a_rdata_value: assert property (@(negedge axis_clk) disable iff (!arst_n)
        rd_pending |-> cfg_rdata == rd_expect)
        else value_mismatch("cfg_rdata", rd_expect, cfg_rdata);

    a_res_expected: assert property (@(negedge axis_clk) disable iff (!arst_n)
        res_valid |-> head_ok[res_kernel])
        else abort_run("result from a kernel with no row outstanding");

    a_res_row: assert property (@(negedge axis_clk) disable iff (!arst_n)
        res_valid |-> res_row == head_row[res_kernel])
        else value_mismatch("res_row", head_row[res_kernel], res_row);

    a_res_data: assert property (@(negedge axis_clk) disable iff (!arst_n)
        res_valid |-> res_data == head_data[res_kernel])
        else value_mismatch("res_data", head_data[res_kernel], res_data);

    task automatic cfg_write(input int k, input int off, input logic [31:0] data);
        @(posedge axis_clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= CFG_AW'(k * WPK + off);
        cfg_wdata <= data;
        @(posedge axis_clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic cfg_read(input int addr);
        int n;
        @(posedge axis_clk);
        cfg_rd   <= 1'b1;
        cfg_addr <= CFG_AW'(addr);
        @(posedge axis_clk);
        cfg_rd <= 1'b0;
        n = 0;
        do begin
            @(negedge axis_clk);
            n++;
            if (n > TMO) abort_run("no cfg_rvalid after a register read");
        end while (!cfg_rvalid);
    endtask

    // top nibble follows the kernel, so one column differs across kernels
    task automatic load_x();
        for (int k = 0; k < NK; k++) begin
            for (int i = 0; i < XD; i++) begin
                @(posedge axis_clk);
                xi_wr    <= 1'b1;
                xi_addr  <= 16'((k << IDX_W) | i);
                xi_wdata <= 16'(((k + 1) << 12) ^ ($urandom & 32'hfff));
            end
        end
        @(posedge axis_clk);
        xi_wr <= 1'b0;
    endtask

    task automatic stream_rows(input int k, input int n_rows);
        int len;
        for (int r = 0; r < n_rows; r++) begin
            len = 1 + $urandom_range(5);
            for (int i = 0; i < len; i++) begin
                @(posedge axis_clk);
                nz_valid[k] <= 1'b1;
                nz_col[k]   <= 16'($urandom_range(XD - 1));
                nz_val[k]   <= 16'($urandom);
                nz_last[k]  <= (i == len - 1);
            end
            @(posedge axis_clk);
            nz_valid[k] <= 1'b0;
            nz_last[k]  <= 1'b0;
            repeat (NK) @(posedge axis_clk);  // row spacing for the arbiter slots
        end
        streams_done++;
    endtask

    task automatic run_rows(input logic [NK-1:0] mask, input int n_rows);
        int want;
        int n;
        streams_done = 0;
        want         = $countones(mask);
        for (int k = 0; k < NK; k++) begin
            if (mask[k]) begin
                fork
                    automatic int kk = k;
                    stream_rows(kk, n_rows);
                join_none
            end
        end
        n = 0;
        while (streams_done < want) begin
            @(posedge axis_clk);
            n++;
            if (n > TMO * n_rows) abort_run("nonzero streams did not finish");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (outstanding() != 0) begin
            @(negedge axis_clk);
            n++;
            if (n > TMO) abort_run("expected row results never arrived");
        end
    endtask

    initial begin : stimulus
        int          n;
        logic [31:0] ctl_word;
        void'($urandom(77));
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        xi_wr     = 1'b0;
        xi_addr   = '0;
        xi_wdata  = '0;
        nz_valid  = '0;
        nz_col    = '0;
        nz_val    = '0;
        nz_last   = '0;
        n = 0;
        while (arst_n !== 1'b1) begin
            @(posedge axis_clk);
            n++;
            if (n > TMO) abort_run("reset never released");
        end
        repeat (4) @(posedge axis_clk);  // quiet outputs with no request

        load_x();
        for (int k = 0; k < NK; k++) begin
            ctl_word       = $urandom;  // reserved bits must read back raw
            ctl_word[SOFT] = 1'b0;
            ctl_word[EN]   = 1'b1;
            cfg_write(k, spmv_regmap_pkg::CFG_ROW_BASE, $urandom);
            cfg_write(k, spmv_regmap_pkg::CFG_CTRL, ctl_word);
        end
        for (int a = 0; a < (1 << CFG_AW); a++) begin
            cfg_read(a);  // includes the unmapped tail
        end

        run_rows('1, 8);
        wait_drained();
        for (int k = 0; k < NK; k++) begin
            cfg_read(k * WPK + spmv_regmap_pkg::CFG_ROWS_DONE);
        end

        // kernel 1 disabled while kernel 0 keeps running
        cfg_write(1, spmv_regmap_pkg::CFG_CTRL, 32'h0);
        run_rows(NK'(3), 3);
        wait_drained();
        repeat (8) @(posedge axis_clk);
        cfg_read(1 * WPK + spmv_regmap_pkg::CFG_ROWS_DONE);

        // soft reset pulse, then enable again
        cfg_write(1, spmv_regmap_pkg::CFG_CTRL, 32'h1 << SOFT);
        cfg_write(1, spmv_regmap_pkg::CFG_CTRL, 32'h1 << EN);
        cfg_read(1 * WPK + spmv_regmap_pkg::CFG_CTRL);
        cfg_read(1 * WPK + spmv_regmap_pkg::CFG_ROWS_DONE);
        cfg_write(2, spmv_regmap_pkg::CFG_ROW_BASE, $urandom);
        run_rows('1, 4);
        wait_drained();
        for (int k = 0; k < NK; k++) begin
            cfg_read(k * WPK + spmv_regmap_pkg::CFG_ROWS_DONE);
        end
        repeat (8) @(posedge axis_clk);

        if (outstanding() == 0 && !res_valid) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("row results left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: project.f
spmv_types_pkg.sv
spmv_regmap_pkg.sv
spmv_system_config.sv
xi_buffer.sv
spmv_calc_kernel.sv
result_arbiter.sv
spmv_calc_top.sv
tb_clock_gen.sv
tb_spmv_calc_top.sv
